/* hdl/hdc_defines.svh */
`ifndef HDC_DEFINES_SVH
`define HDC_DEFINES_SVH

// cores running in lockstep
`define HDC_NUM_CORES 4

// words per item memory
`define HDC_ITEM_DEPTH 128

// item memory address, log2 of depth
`define HDC_ADDR_W 7

// item and accumulator word
`define HDC_WORD_W 32

// core number, log2 of core count
`define HDC_CORE_W 2

`endif

/* hdl/hdc_pkg.sv */
`default_nettype none

`include "hdc_defines.svh"

package hdc_pkg;

    // host command opcodes
    // nop is reserved, decoder flags it
    typedef enum logic [1:0] {
        OP_NOP    = 2'b00,
        OP_LOAD   = 2'b01,
        OP_SRC    = 2'b10,
        OP_FINISH = 2'b11
    } op_e;

    // item or accumulator value
    typedef logic [`HDC_WORD_W-1:0] word_t;

    // item memory address
    typedef logic [`HDC_ADDR_W-1:0] addr_t;

    // core number
    typedef logic [`HDC_CORE_W-1:0] core_idx_t;

endpackage

`default_nettype wire

/* hdl/cmd_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_defines.svh"

module cmd_decoder (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cmd_valid,
    input  hdc_pkg::op_e             cmd_op,
    input  hdc_pkg::core_idx_t       cmd_core,
    input  hdc_pkg::addr_t           cmd_addr,
    input  hdc_pkg::word_t           cmd_data,
    output logic                     load_en,
    output hdc_pkg::core_idx_t       load_core,
    output hdc_pkg::addr_t           load_addr,
    output hdc_pkg::word_t           load_data,
    output logic                     src_en,
    output hdc_pkg::addr_t           src_addr,
    output logic                     finish_en,
    output logic                     bad_cmd
);

    // one-hot decode of the incoming command
    logic is_load;
    logic is_src;
    logic is_finish;
    logic is_bad;

    always_comb begin
        is_load   = 1'b0;
        is_src    = 1'b0;
        is_finish = 1'b0;
        is_bad    = 1'b0;
        if (cmd_valid) begin
            case (cmd_op)
                hdc_pkg::OP_LOAD:   is_load   = 1'b1;
                hdc_pkg::OP_SRC:    is_src    = 1'b1;
                hdc_pkg::OP_FINISH: is_finish = 1'b1;
                // reserved opcode, flag only
                default:            is_bad    = 1'b1;
            endcase
        end
    end

    // strobes, one cycle after the command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_en   <= 1'b0;
            src_en    <= 1'b0;
            finish_en <= 1'b0;
            bad_cmd   <= 1'b0;
        end else begin
            load_en   <= is_load;
            src_en    <= is_src;
            finish_en <= is_finish;
            bad_cmd   <= is_bad;
        end
    end

    // fields ride along with their strobe
    always_ff @(posedge clk) begin
        if (is_load) begin
            load_core <= cmd_core;
            load_addr <= cmd_addr;
            load_data <= cmd_data;
        end
        if (is_src) begin
            src_addr <= cmd_addr;
        end
    end

endmodule

`default_nettype wire

/* hdl/item_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_defines.svh"

module item_core (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wr_en,
    input  hdc_pkg::addr_t           wr_addr,
    input  hdc_pkg::word_t           wr_data,
    input  wire                      src_en,
    input  hdc_pkg::addr_t           src_addr,
    input  wire                      finish_en,
    output hdc_pkg::word_t           sum,
    output logic                     done
);

    // rotate amount is position mod word width
    localparam int POS_W = $clog2(`HDC_WORD_W);

    // block ram style item memory
    hdc_pkg::word_t item_mem [`HDC_ITEM_DEPTH];

    // stage 1, registered strobes and address
    logic           s1_src;
    logic           s1_fin;
    hdc_pkg::addr_t s1_addr;

    // stage 2, item read out with its position
    logic             s2_src;
    logic             s2_fin;
    hdc_pkg::word_t   s2_item;
    logic [POS_W-1:0] s2_pos;

    // index count within current sequence
    logic [POS_W-1:0] pos_cnt;

    hdc_pkg::word_t               acc;
    logic [2*`HDC_WORD_W-1:0]     rot_full;
    hdc_pkg::word_t               rot_item;

    // zero contents at power up
    initial begin
        for (int i = 0; i < `HDC_ITEM_DEPTH; i++) begin
            item_mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            item_mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_src  <= 1'b0;
            s1_fin  <= 1'b0;
            s2_src  <= 1'b0;
            s2_fin  <= 1'b0;
            pos_cnt <= '0;
        end else begin
            s1_src <= src_en;
            s1_fin <= finish_en;
            s2_src <= s1_src;
            s2_fin <= s1_fin;
            // finish restarts numbering for the next sequence
            if (s1_fin) begin
                pos_cnt <= '0;
            end else if (s1_src) begin
                pos_cnt <= pos_cnt + 1'b1;
            end
        end
    end

    // address and memory read
    always_ff @(posedge clk) begin
        s1_addr <= src_addr;
        if (s1_src) begin
            s2_item <= item_mem[s1_addr];
            s2_pos  <= pos_cnt;
        end
    end

    // rotate right through a doubled word
    assign rot_full = {s2_item, s2_item} >> s2_pos;
    assign rot_item = rot_full[`HDC_WORD_W-1:0];

    // stage 3, accumulate or close the sequence
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc  <= '0;
            done <= 1'b0;
        end else begin
            done <= s2_fin;
            if (s2_fin) begin
                acc <= '0;
            end else if (s2_src) begin
                acc <= acc + rot_item;
            end
        end
    end

    // final value held for the done cycle
    always_ff @(posedge clk) begin
        if (s2_fin) begin
            sum <= acc;
        end
    end

endmodule

`default_nettype wire

/* hdl/core_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_defines.svh"

module core_array (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       load_en,
    input  hdc_pkg::core_idx_t                        load_core,
    input  hdc_pkg::addr_t                            load_addr,
    input  hdc_pkg::word_t                            load_data,
    input  wire                                       src_en,
    input  hdc_pkg::addr_t                            src_addr,
    input  wire                                       finish_en,
    output logic [`HDC_NUM_CORES*`HDC_WORD_W-1:0]     sums,
    output logic                                      done
);

    // write enable per core, one hot
    logic [`HDC_NUM_CORES-1:0] wr_sel;

    // done from each lane, all identical
    logic [`HDC_NUM_CORES-1:0] core_done;

    genvar g;
    generate
        for (g = 0; g < `HDC_NUM_CORES; g++) begin : g_core
            hdc_pkg::word_t core_sum;

            // steer load to the addressed core only
            assign wr_sel[g] = load_en && (load_core == hdc_pkg::core_idx_t'(g));

            item_core u_core (
                .clk       (clk),
                .rst_n     (rst_n),
                .wr_en     (wr_sel[g]),
                .wr_addr   (load_addr),
                .wr_data   (load_data),
                .src_en    (src_en),
                .src_addr  (src_addr),
                .finish_en (finish_en),
                .sum       (core_sum),
                .done      (core_done[g])
            );

            // core 0 in the low word
            assign sums[g*`HDC_WORD_W +: `HDC_WORD_W] = core_sum;
        end
    endgenerate

    // lanes run in lockstep
    // core 0 speaks for all
    assign done = core_done[0];

endmodule

`default_nettype wire

/* hdl/result_collector.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_defines.svh"

module result_collector #(
    parameter int NUM_CORES = 4
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   done,
    input  wire [NUM_CORES*`HDC_WORD_W-1:0]       sums,
    output logic                                  result_valid,
    output logic [((NUM_CORES > 1) ? $clog2(NUM_CORES) : 1)-1:0] result_core,
    output logic [`HDC_WORD_W-1:0]                result_data
);

    // core index and remaining beat widths
    localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
    localparam int CNT_W = $clog2(NUM_CORES + 1);

    // snapshot of all accumulators
    logic [`HDC_WORD_W-1:0] bank [NUM_CORES];

    // beats still to send and next core to send
    logic [CNT_W-1:0] beats_left;
    logic [IDX_W-1:0] rd_idx;

    // capture side
    always_ff @(posedge clk) begin
        if (done) begin
            for (int i = 0; i < NUM_CORES; i++) begin
                bank[i] <= sums[i*`HDC_WORD_W +: `HDC_WORD_W];
            end
        end
    end

    // beat counter, a new done restarts the drain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beats_left <= '0;
            rd_idx     <= '0;
        end else if (done) begin
            beats_left <= CNT_W'(NUM_CORES);
            rd_idx     <= '0;
        end else if (beats_left != '0) begin
            beats_left <= beats_left - 1'b1;
            rd_idx     <= rd_idx + 1'b1;
        end
    end

    // registered output, one word per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= (beats_left != '0);
        end
    end

    // payload, core 0 first
    always_ff @(posedge clk) begin
        if (beats_left != '0) begin
            result_core <= rd_idx;
            result_data <= bank[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* hdl/hdc_accel_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_defines.svh"

module hdc_accel_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cmd_valid,
    input  hdc_pkg::op_e             cmd_op,
    input  hdc_pkg::core_idx_t       cmd_core,
    input  hdc_pkg::addr_t           cmd_addr,
    input  hdc_pkg::word_t           cmd_data,
    output logic                     result_valid,
    output hdc_pkg::core_idx_t       result_core,
    output hdc_pkg::word_t           result_data,
    output logic                     bad_cmd
);

    // decoder to core array
    logic                   load_en;
    hdc_pkg::core_idx_t     load_core;
    hdc_pkg::addr_t         load_addr;
    hdc_pkg::word_t         load_data;
    logic                   src_en;
    hdc_pkg::addr_t         src_addr;
    logic                   finish_en;

    // core array to collector
    logic [`HDC_NUM_CORES*`HDC_WORD_W-1:0] sums;
    logic                                  done;

    cmd_decoder u_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_core  (cmd_core),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .load_en   (load_en),
        .load_core (load_core),
        .load_addr (load_addr),
        .load_data (load_data),
        .src_en    (src_en),
        .src_addr  (src_addr),
        .finish_en (finish_en),
        .bad_cmd   (bad_cmd)
    );

    core_array u_cores (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_core (load_core),
        .load_addr (load_addr),
        .load_data (load_data),
        .src_en    (src_en),
        .src_addr  (src_addr),
        .finish_en (finish_en),
        .sums      (sums),
        .done      (done)
    );

    result_collector #(
        .NUM_CORES (`HDC_NUM_CORES)
    ) u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .done         (done),
        .sums         (sums),
        .result_valid (result_valid),
        .result_core  (result_core),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

/* tb/hdc_accel_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_defines.svh"

module hdc_accel_assertions (
    input wire                clk,
    input wire                rst_n,
    input wire                cmd_valid,
    input hdc_pkg::op_e       cmd_op,
    input wire                done,
    input wire                result_valid,
    input hdc_pkg::core_idx_t result_core,
    input wire                bad_cmd
);

    localparam int NUM_CORES = `HDC_NUM_CORES;

    // failed assertions so far
    int fail_count = 0;

    logic fin_cmd;
    logic nop_cmd;

    assign fin_cmd = cmd_valid && (cmd_op == hdc_pkg::OP_FINISH);
    assign nop_cmd = cmd_valid && (cmd_op == hdc_pkg::OP_NOP);

    // quiet outputs while reset is held
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !result_valid && !bad_cmd)
        else begin
            $error("result_valid or bad_cmd high after a reset cycle");
            fail_count++;
        end

    // drain starts two cycles after done
    a_done_to_beats: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> ##2 result_valid)
        else begin
            $error("no result beat two cycles after done");
            fail_count++;
        end

    // first beat comes from core 0, only after a done
    a_first_beat: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(result_valid) |-> $past(done, 2) && (result_core == '0))
        else begin
            $error("result drain started without done or not at core 0");
            fail_count++;
        end

    // core index steps by one per beat
    a_core_step: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && $past(result_valid) |->
            int'(result_core) == int'($past(result_core)) + 1)
        else begin
            $error("result_core did not step by one");
            fail_count++;
        end

    // drain ends on the last core
    a_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(result_valid) |-> int'($past(result_core)) == NUM_CORES - 1)
        else begin
            $error("result drain ended before the last core");
            fail_count++;
        end

    // host keeps finishes five cycles apart
    a_finish_gap: assert property (@(posedge clk) disable iff (!rst_n)
        fin_cmd |-> !$past(fin_cmd, 1) && !$past(fin_cmd, 2) &&
                    !$past(fin_cmd, 3) && !$past(fin_cmd, 4))
        else begin
            $error("finish command arrived during a result drain");
            fail_count++;
        end

    // bad_cmd one cycle after a reserved opcode, never otherwise
    a_bad_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        bad_cmd == $past(nop_cmd))
        else begin
            $error("bad_cmd does not follow the reserved opcode");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb/hdc_accel_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hdc_defines.svh"

module hdc_accel_tb;

    localparam int NUM_CORES = `HDC_NUM_CORES;
    localparam int DEPTH     = `HDC_ITEM_DEPTH;

    // rough cycle cost of each test
    localparam int LEN_RESET  = 5 + 20;
    localparam int LEN_SINGLE = NUM_CORES * (NUM_CORES + 20);
    localparam int LEN_ROTATE = NUM_CORES * DEPTH + 40 + 20;
    localparam int LEN_CLEAR  = 2 * 20 + 30;
    localparam int LEN_BADOP  = 2 * 12 + 30;
    localparam int CYCLE_LIMIT = LEN_RESET + LEN_SINGLE + LEN_ROTATE + LEN_CLEAR + LEN_BADOP + 50;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               cmd_valid;
    hdc_pkg::op_e       cmd_op;
    hdc_pkg::core_idx_t cmd_core;
    hdc_pkg::addr_t     cmd_addr;
    hdc_pkg::word_t     cmd_data;
    logic               result_valid;
    hdc_pkg::core_idx_t result_core;
    hdc_pkg::word_t     result_data;
    logic               bad_cmd;

    // shadow of every item memory
    hdc_pkg::word_t shadow [NUM_CORES][DEPTH];

    // model accumulators and position within sequence
    hdc_pkg::word_t model_acc [NUM_CORES];
    int             model_pos = 0;

    // expected beats, oldest first
    hdc_pkg::word_t     exp_data_q [$];
    hdc_pkg::core_idx_t exp_core_q [$];

    int cycle_cnt    = 0;
    int err_cnt      = 0;
    int beat_cnt     = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    // 8 ns period
    always #4 clk = ~clk;

    hdc_accel_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_core     (cmd_core),
        .cmd_addr     (cmd_addr),
        .cmd_data     (cmd_data),
        .result_valid (result_valid),
        .result_core  (result_core),
        .result_data  (result_data),
        .bad_cmd      (bad_cmd)
    );

    // protocol checks on the top level
    bind hdc_accel_top hdc_accel_assertions asrt0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .done         (done),
        .result_valid (result_valid),
        .result_core  (result_core),
        .bad_cmd      (bad_cmd)
    );

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // compare each beat with the model, mid cycle
    always @(negedge clk) begin : check_beat
        hdc_pkg::word_t     exp_d;
        hdc_pkg::core_idx_t exp_c;
        if (rst_n && result_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("unexpected result beat at %0t, no result was pending", $time);
                err_cnt++;
            end else begin
                exp_d = exp_data_q.pop_front();
                exp_c = exp_core_q.pop_front();
                beat_cnt++;
                assert (result_core == exp_c) else begin
                    $display("[ERROR] %0t result_core expected %0d got %0d",
                             $time, exp_c, result_core);
                    err_cnt++;
                end
                assert (result_data == exp_d) else begin
                    $display("[ERROR] %0t result_data expected %08h got %08h",
                             $time, exp_d, result_data);
                    err_cnt++;
                end
            end
        end
    end

    // right rotate, written out from the shift pair
    function automatic hdc_pkg::word_t rotate_right(input hdc_pkg::word_t w, input int n);
        int k;
        k = n % `HDC_WORD_W;
        if (k == 0) begin
            return w;
        end
        return (w >> k) | (w << (`HDC_WORD_W - k));
    endfunction

    // value errors plus bound assertion failures
    function automatic int total_errors();
        return err_cnt + dut0.asrt0.fail_count;
    endfunction

    // one command slot, back to back allowed
    task automatic drive_cmd(input hdc_pkg::op_e op, input int core, input int addr,
                             input hdc_pkg::word_t data);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_core  <= hdc_pkg::core_idx_t'(core);
        cmd_addr  <= hdc_pkg::addr_t'(addr);
        cmd_data  <= data;
    endtask

    task automatic bus_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    task automatic load_item(input int core, input int addr, input hdc_pkg::word_t data);
        shadow[core][addr] = data;
        drive_cmd(hdc_pkg::OP_LOAD, core, addr, data);
    endtask

    // every core sees the same index
    task automatic stream_index(input int addr);
        for (int c = 0; c < NUM_CORES; c++) begin
            model_acc[c] = model_acc[c] + rotate_right(shadow[c][addr], model_pos);
        end
        model_pos++;
        drive_cmd(hdc_pkg::OP_SRC, 0, addr, '0);
    endtask

    // queue the closing sums, core 0 first, then restart the model
    task automatic finish_seq();
        for (int c = 0; c < NUM_CORES; c++) begin
            exp_data_q.push_back(model_acc[c]);
            exp_core_q.push_back(hdc_pkg::core_idx_t'(c));
            model_acc[c] = '0;
        end
        model_pos = 0;
        drive_cmd(hdc_pkg::OP_FINISH, 0, 0, '0);
    endtask

    task automatic wait_results();
        bus_idle(1);
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
        // output drops after the last beat
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, total_errors() - errs_before);
        end
    endtask

    initial begin
        int errs;
        int addr;
        void'($urandom(84));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = hdc_pkg::OP_NOP;
        cmd_core  = '0;
        cmd_addr  = '0;
        cmd_data  = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            model_acc[c] = '0;
            for (int a = 0; a < DEPTH; a++) begin
                shadow[c][a] = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // idle outputs after reset
        errs = total_errors();
        repeat (10) begin
            @(negedge clk);
            assert (!result_valid) else begin
                $display("[ERROR] %0t result_valid expected 0 got %0b", $time, result_valid);
                err_cnt++;
            end
            assert (!bad_cmd) else begin
                $display("[ERROR] %0t bad_cmd expected 0 got %0b", $time, bad_cmd);
                err_cnt++;
            end
        end
        end_test("reset", errs);

        // one index per sequence, position 0 so no rotation
        errs = total_errors();
        for (int n = 0; n < NUM_CORES; n++) begin
            addr = $urandom_range(DEPTH - 1);
            for (int c = 0; c < NUM_CORES; c++) begin
                load_item(c, addr, $urandom());
            end
            stream_index(addr);
            finish_seq();
            wait_results();
        end
        end_test("single item", errs);

        // full memories, then 40 indices wrapping the position
        errs = total_errors();
        for (int c = 0; c < NUM_CORES; c++) begin
            for (int a = 0; a < DEPTH; a++) begin
                load_item(c, a, $urandom());
            end
        end
        for (int i = 0; i < 40; i++) begin
            stream_index($urandom_range(DEPTH - 1));
        end
        finish_seq();
        wait_results();
        end_test("rotate and accumulate", errs);

        // second sequence right behind a finish
        errs = total_errors();
        for (int i = 0; i < 20; i++) begin
            stream_index($urandom_range(DEPTH - 1));
        end
        finish_seq();
        for (int i = 0; i < 20; i++) begin
            stream_index($urandom_range(DEPTH - 1));
        end
        finish_seq();
        wait_results();
        end_test("clear on finish", errs);

        // reserved opcode mixed into a sequence
        errs = total_errors();
        for (int i = 0; i < 12; i++) begin
            addr = $urandom_range(DEPTH - 1);
            // a stray write would land on the index read next
            drive_cmd(hdc_pkg::OP_NOP, $urandom_range(NUM_CORES - 1), addr, $urandom());
            stream_index(addr);
        end
        finish_seq();
        wait_results();
        end_test("reserved opcode", errs);

        bus_idle(5);
        $display("summary: %0d tests, %0d failed, %0d beats checked, %0d errors",
                 tests_run, tests_failed, beat_cnt, total_errors());
        if (total_errors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/hdc_pkg.sv
hdl/cmd_decoder.sv
hdl/item_core.sv
hdl/core_array.sv
hdl/result_collector.sv
hdl/hdc_accel_top.sv
tb/hdc_accel_assertions.sv
tb/hdc_accel_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module hdc_accel_tb -Mdir obj_dir -f filelist.f \
    || { echo "verilator build failed"; exit 1; }

# keep running past assertion errors so the summary is printed
out=$(./obj_dir/Vhdc_accel_tb +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "STATUS: PASS" && exit 0 || exit 1
